// ==== build.f ====
+incdir+include
hdl/rx_pkg.sv
hdl/legacy_sig_check.sv
hdl/ht_phase_vote.sv
hdl/ht_sig_check.sv
hdl/fcs_check.sv
hdl/rx_ctrl.sv
hdl/rx_frame_top.sv
test/rx_frame_tb.sv

// ==== hdl/fcs_check.sv ====
`timescale 1ns/10ps
`include "rx_settings.svh"

module fcs_check
    import rx_pkg::*;
(
    input  logic        clock,
    input  logic        ofdm_reset,
    input  logic        arm_i,
    input  logic [15:0] len_i,
    input  logic        byte_stb_i,
    input  logic [7:0]  byte_i,
    output logic        done_o,
    output logic        ok_o
);

    logic [15:0] byte_cnt;
    logic [31:0] crc_q;
    logic [31:0] crc_nxt;
    logic        finished;

    // reflected ieee crc-32 with the lsb of each byte first
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input logic [7:0] d);
        logic [31:0] c;
        c = crc;
        for (int b = 0; b < 8; b++) begin
            c = (c[0] ^ d[b]) ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
        end
        return c;
    endfunction

    assign crc_nxt = crc32_byte(crc_q, byte_i);

    always_ff @(posedge clock) begin
        if (ofdm_reset || !arm_i) begin
            byte_cnt <= '0;
            crc_q    <= '1;
            finished <= 1'b0;
            done_o   <= 1'b0;
            ok_o     <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (!finished) begin
                if (len_i == 16'd0) begin
                    // nothing to check
                    done_o   <= 1'b1;
                    ok_o     <= crc_q == `RX_FCS_RESIDUE;
                    finished <= 1'b1;
                end else if (byte_stb_i) begin
                    crc_q    <= crc_nxt;
                    byte_cnt <= byte_cnt + 16'd1;
                    if (byte_cnt + 16'd1 == len_i) begin
                        done_o   <= 1'b1;
                        ok_o     <= crc_nxt == `RX_FCS_RESIDUE;
                        finished <= 1'b1;
                    end
                end
            end
        end
    end

    a_count_in_len: assert property (@(posedge clock) disable iff (ofdm_reset)
        arm_i |-> byte_cnt <= len_i)
        else $error("fcs byte count beyond packet length");

endmodule

// ==== hdl/ht_phase_vote.sv ====
`timescale 1ns/10ps
`include "rx_settings.svh"

module ht_phase_vote
    import rx_pkg::*;
(
    input  logic       clock,
    input  logic       ofdm_reset,
    input  logic       arm_i,
    input  logic       sym_stb_i,
    input  iq_sample_t sym_i,
    output logic       is_ht_o,
    output logic       is_legacy_o
);

    logic [`RX_IQ_WIDTH-1:0] abs_i;
    logic [`RX_IQ_WIDTH-1:0] abs_q;
    logic                    rotated;
    logic [2:0]              rot_cnt;
    logic [2:0]              norm_cnt;
    logic                    decided;

    // magnitudes of this sample
    // negative full scale still fits unsigned
    always_comb begin
        abs_i   = sym_i.i[`RX_IQ_WIDTH-1] ? -sym_i.i : sym_i.i;
        abs_q   = sym_i.q[`RX_IQ_WIDTH-1] ? -sym_i.q : sym_i.q;
        rotated = abs_q > abs_i;
    end

    always_ff @(posedge clock) begin
        if (ofdm_reset || !arm_i) begin
            rot_cnt     <= '0;
            norm_cnt    <= '0;
            decided     <= 1'b0;
            is_ht_o     <= 1'b0;
            is_legacy_o <= 1'b0;
        end else begin
            is_ht_o     <= 1'b0;
            is_legacy_o <= 1'b0;
            if (sym_stb_i && !decided) begin
                if (rotated) begin
                    rot_cnt <= rot_cnt + 3'd1;
                    if (rot_cnt + 3'd1 == 3'(`RX_HT_ROT_VOTES)) begin
                        is_ht_o <= 1'b1;
                        decided <= 1'b1;
                    end
                end else begin
                    norm_cnt <= norm_cnt + 3'd1;
                    if (norm_cnt + 3'd1 == 3'(`RX_LEGACY_VOTES)) begin
                        is_legacy_o <= 1'b1;
                        decided     <= 1'b1;
                    end
                end
            end
        end
    end

    a_one_decision: assert property (@(posedge clock) disable iff (ofdm_reset)
        (is_ht_o || is_legacy_o) |=> !(is_ht_o || is_legacy_o))
        else $error("second ht or legacy decision after the first");

endmodule

// ==== hdl/ht_sig_check.sv ====
`timescale 1ns/10ps
`include "rx_settings.svh"

module ht_sig_check
    import rx_pkg::*;
(
    input  logic       clock,
    input  logic       ofdm_reset,
    input  logic       arm_i,
    input  logic       byte_stb_i,
    input  logic [7:0] byte_i,
    output logic       done_o,
    output ht_sig_t    ht_sig_o,
    output logic       crc_ok_o,
    output rx_status_t verdict_o
);

    logic [2:0] byte_cnt;
    logic [5:0] bit_cnt;
    logic [7:0] crc_q;
    logic [7:0] crc_exp;
    logic       collecting;
    logic       fb;

    assign collecting = byte_cnt < 3'(`RX_HT_SIG_BYTES);
    assign fb         = crc_q[7] ^ ht_sig_o[bit_cnt];

    //////////////////////////////
    // collection and serial crc-8
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (ofdm_reset || !arm_i) begin
            byte_cnt <= '0;
            bit_cnt  <= '0;
            crc_q    <= 8'hff;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (collecting) begin
                if (byte_stb_i) begin
                    byte_cnt <= byte_cnt + 3'd1;
                end
            end else if (bit_cnt < 6'(`RX_HT_CRC_BITS)) begin
                // x^8 + x^2 + x + 1, one field bit per cycle
                crc_q   <= {crc_q[6:0], 1'b0} ^ (fb ? 8'h07 : 8'h00);
                bit_cnt <= bit_cnt + 6'd1;
                if (bit_cnt == 6'(`RX_HT_CRC_BITS - 1)) begin
                    done_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (arm_i && collecting && byte_stb_i) begin
            ht_sig_o <= {byte_i, ht_sig_o[47:8]};
        end
    end

    //////////////////////////////
    // verdict
    //////////////////////////////

    // transmitted crc is the register complemented and bit reversed
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            crc_exp[k] = ~crc_q[7-k];
        end
    end

    assign crc_ok_o = ht_sig_o.crc == crc_exp;

    always_comb begin
        if (!crc_ok_o) begin
            verdict_o = WRONG_CRC;
        end else if (ht_sig_o.mcs > 7'(`RX_MAX_MCS)) begin
            verdict_o = UNSUPPORTED_MCS;
        end else if (ht_sig_o.cbw) begin
            verdict_o = UNSUPPORTED_CBW;
        end else if (!ht_sig_o.rsvd) begin
            verdict_o = HT_WRONG_RSVD;
        end else if (|ht_sig_o.stbc) begin
            verdict_o = UNSUPPORTED_STBC;
        end else if (ht_sig_o.fec) begin
            verdict_o = UNSUPPORTED_FEC;
        end else if (|ht_sig_o.num_ext) begin
            verdict_o = UNSUPPORTED_SPATIAL;
        end else if (|ht_sig_o.tail) begin
            verdict_o = HT_WRONG_TAIL;
        end else begin
            verdict_o = OK;
        end
    end

endmodule

// ==== hdl/legacy_sig_check.sv ====
`timescale 1ns/10ps
`include "rx_settings.svh"

module legacy_sig_check
    import rx_pkg::*;
(
    input  logic        clock,
    input  logic        ofdm_reset,
    input  logic        arm_i,
    input  logic        byte_stb_i,
    input  logic [7:0]  byte_i,
    output logic        done_o,
    output legacy_sig_t sig_o,
    output rx_status_t  verdict_o
);

    logic [1:0] byte_cnt;
    logic       accept;

    // extra bytes after the third are dropped
    assign accept = arm_i && byte_stb_i && (byte_cnt < 2'(`RX_SIG_BYTES));

    always_ff @(posedge clock) begin
        if (ofdm_reset || !arm_i) begin
            byte_cnt <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (accept) begin
                byte_cnt <= byte_cnt + 2'd1;
                if (byte_cnt == 2'(`RX_SIG_BYTES - 1)) begin
                    done_o <= 1'b1;
                end
            end
        end
    end

    // first byte ends up in the low bits
    always_ff @(posedge clock) begin
        if (accept) begin
            sig_o <= {byte_i, sig_o[23:8]};
        end
    end

    always_comb begin
        if (^sig_o[17:0]) begin
            verdict_o = PARITY_FAIL;
        end else if (sig_o.rsvd) begin
            verdict_o = WRONG_RSVD;
        end else if (|sig_o.tail) begin
            verdict_o = WRONG_TAIL;
        end else begin
            verdict_o = OK;
        end
    end

endmodule

// ==== hdl/rx_ctrl.sv ====
`timescale 1ns/10ps
`include "rx_settings.svh"

module rx_ctrl
    import rx_pkg::*;
(
    input  logic        clock,
    input  logic        ofdm_reset,
    input  logic        start_i,
    input  logic        sig_done_i,
    input  legacy_sig_t sig_i,
    input  rx_status_t  sig_verdict_i,
    input  logic        is_ht_i,
    input  logic        is_legacy_i,
    input  logic        ht_done_i,
    input  ht_sig_t     ht_sig_i,
    input  logic        ht_crc_ok_i,
    input  rx_status_t  ht_verdict_i,
    input  logic        fcs_done_i,
    input  logic        fcs_ok_i,
    output logic        sig_arm_o,
    output logic        vote_arm_o,
    output logic        ht_arm_o,
    output logic        fcs_arm_o,
    output logic [15:0] fcs_len_o,
    output logic        sig_stb_o,
    output legacy_sig_t sig_o,
    output logic        ht_sig_stb_o,
    output ht_sig_t     ht_sig_o,
    output logic        ht_sig_crc_ok_o,
    output logic        pkt_begin_o,
    output pkt_info_t   pkt_o,
    output logic        fcs_stb_o,
    output logic        fcs_ok_o,
    output rx_status_t  status_o
);

    rx_state_t state;
    logic      legacy_go;
    logic      ht_go;

    // units stay armed through their check state so the verdicts hold
    assign sig_arm_o  = (state == SIGNAL) || (state == CHECK_SIGNAL);
    assign vote_arm_o = state == DETECT_HT;
    assign ht_arm_o   = (state == HT_SIGNAL) || (state == CHECK_HT_SIG);
    assign fcs_arm_o  = state == DATA;
    assign fcs_len_o  = pkt_o.len;

    assign legacy_go = (state == CHECK_SIGNAL && sig_verdict_i == OK &&
                        sig_o.rate != `RX_BPSK_RATE) ||
                       (state == DETECT_HT && is_legacy_i);
    assign ht_go     = state == CHECK_HT_SIG && ht_verdict_i == OK;

    //////////////////////////////
    // packet fsm
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (ofdm_reset) begin
            state           <= IDLE;
            sig_stb_o       <= 1'b0;
            ht_sig_stb_o    <= 1'b0;
            ht_sig_crc_ok_o <= 1'b0;
            pkt_begin_o     <= 1'b0;
            fcs_stb_o       <= 1'b0;
            fcs_ok_o        <= 1'b0;
            status_o        <= OK;
        end else begin
            sig_stb_o    <= 1'b0;
            ht_sig_stb_o <= 1'b0;
            pkt_begin_o  <= legacy_go || ht_go;
            fcs_stb_o    <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_i) begin
                        state <= SIGNAL;
                    end
                end
                SIGNAL: begin
                    if (sig_done_i) begin
                        sig_stb_o <= 1'b1;
                        state     <= CHECK_SIGNAL;
                    end
                end
                CHECK_SIGNAL: begin
                    status_o <= sig_verdict_i;
                    if (sig_verdict_i != OK) begin
                        state <= SIGNAL_ERROR;
                    end else if (legacy_go) begin
                        state <= DATA;
                    end else begin
                        state <= DETECT_HT;
                    end
                end
                DETECT_HT: begin
                    if (is_ht_i) begin
                        state <= HT_SIGNAL;
                    end else if (is_legacy_i) begin
                        state <= DATA;
                    end
                end
                HT_SIGNAL: begin
                    if (ht_done_i) begin
                        ht_sig_stb_o    <= 1'b1;
                        ht_sig_crc_ok_o <= ht_crc_ok_i;
                        state           <= CHECK_HT_SIG;
                    end
                end
                CHECK_HT_SIG: begin
                    status_o <= ht_verdict_i;
                    state    <= ht_go ? DATA : HT_SIG_ERROR;
                end
                DATA: begin
                    if (fcs_done_i) begin
                        fcs_stb_o <= 1'b1;
                        fcs_ok_o  <= fcs_ok_i;
                        status_o  <= fcs_ok_i ? OK : WRONG_FCS;
                        state     <= DONE;
                    end
                end
                default: begin
                    // error states and DONE
                    state <= IDLE;
                end
            endcase
        end
    end

    //////////////////////////////
    // field and packet registers
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (state == SIGNAL && sig_done_i) begin
            sig_o <= sig_i;
        end
        if (state == HT_SIGNAL && ht_done_i) begin
            ht_sig_o <= ht_sig_i;
        end
        if (legacy_go) begin
            pkt_o <= '{ht: 1'b0, rate: {4'b0, sig_o.rate}, len: {4'b0, sig_o.len}};
        end else if (ht_go) begin
            pkt_o <= '{ht: 1'b1, rate: {1'b1, ht_sig_o.mcs}, len: ht_sig_o.len};
        end
    end

    a_begin_pulse: assert property (@(posedge clock) disable iff (ofdm_reset)
        pkt_begin_o |=> !pkt_begin_o)
        else $error("pkt_begin held for more than one cycle");

    a_fcs_pulse: assert property (@(posedge clock) disable iff (ofdm_reset)
        fcs_stb_o |=> !fcs_stb_o)
        else $error("fcs strobe held for more than one cycle");

endmodule

// ==== hdl/rx_frame_top.sv ====
`timescale 1ns/10ps

module rx_frame_top
    import rx_pkg::*;
(
    input  logic        clock,
    input  logic        ofdm_reset,
    input  logic        start_i,
    input  logic        byte_stb_i,
    input  logic [7:0]  byte_i,
    input  logic        sym_stb_i,
    input  iq_sample_t  sym_i,
    output logic        sig_stb_o,
    output legacy_sig_t sig_o,
    output logic        ht_sig_stb_o,
    output ht_sig_t     ht_sig_o,
    output logic        ht_sig_crc_ok_o,
    output logic        pkt_begin_o,
    output pkt_info_t   pkt_o,
    output logic        fcs_stb_o,
    output logic        fcs_ok_o,
    output rx_status_t  status_o
);

    logic        sig_arm, vote_arm, ht_arm, fcs_arm;
    logic [15:0] fcs_len;
    logic        sig_done, ht_done, fcs_done;
    logic        is_ht, is_legacy, ht_crc_ok, fcs_ok;
    legacy_sig_t sig_field;
    ht_sig_t     ht_field;
    rx_status_t  sig_verdict, ht_verdict;

    rx_ctrl u_ctrl (
        .clock, .ofdm_reset, .start_i,
        .sig_done_i(sig_done), .sig_i(sig_field), .sig_verdict_i(sig_verdict),
        .is_ht_i(is_ht), .is_legacy_i(is_legacy),
        .ht_done_i(ht_done), .ht_sig_i(ht_field), .ht_crc_ok_i(ht_crc_ok),
        .ht_verdict_i(ht_verdict), .fcs_done_i(fcs_done), .fcs_ok_i(fcs_ok),
        .sig_arm_o(sig_arm), .vote_arm_o(vote_arm), .ht_arm_o(ht_arm),
        .fcs_arm_o(fcs_arm), .fcs_len_o(fcs_len),
        .sig_stb_o, .sig_o, .ht_sig_stb_o, .ht_sig_o, .ht_sig_crc_ok_o,
        .pkt_begin_o, .pkt_o, .fcs_stb_o, .fcs_ok_o, .status_o
    );

    legacy_sig_check u_sig (
        .clock, .ofdm_reset, .arm_i(sig_arm), .byte_stb_i, .byte_i,
        .done_o(sig_done), .sig_o(sig_field), .verdict_o(sig_verdict)
    );

    ht_phase_vote u_vote (
        .clock, .ofdm_reset, .arm_i(vote_arm), .sym_stb_i, .sym_i,
        .is_ht_o(is_ht), .is_legacy_o(is_legacy)
    );

    ht_sig_check u_ht_sig (
        .clock, .ofdm_reset, .arm_i(ht_arm), .byte_stb_i, .byte_i,
        .done_o(ht_done), .ht_sig_o(ht_field), .crc_ok_o(ht_crc_ok),
        .verdict_o(ht_verdict)
    );

    fcs_check u_fcs (
        .clock, .ofdm_reset, .arm_i(fcs_arm), .len_i(fcs_len), .byte_stb_i, .byte_i,
        .done_o(fcs_done), .ok_o(fcs_ok)
    );

endmodule

// ==== hdl/rx_pkg.sv ====
`include "rx_settings.svh"

package rx_pkg;

    typedef struct packed {
        logic signed [`RX_IQ_WIDTH-1:0] i;
        logic signed [`RX_IQ_WIDTH-1:0] q;
    } iq_sample_t;

    // legacy SIGNAL, bit 0 arrives first
    typedef struct packed {
        logic [5:0]  tail;
        logic        parity;
        logic [11:0] len;
        logic        rsvd;
        logic [3:0]  rate;
    } legacy_sig_t;

    // upper 24 bits are HT-SIG2, lower 24 bits HT-SIG1
    typedef struct packed {
        logic [5:0]  tail;
        logic [7:0]  crc;
        logic [1:0]  num_ext;
        logic        sgi;
        logic        fec;
        logic [1:0]  stbc;
        logic        aggregation;
        logic        rsvd;
        logic        not_sounding;
        logic        smoothing;
        logic [15:0] len;
        logic        cbw;
        logic [6:0]  mcs;
    } ht_sig_t;

    typedef struct packed {
        logic        ht;
        logic [7:0]  rate;
        logic [15:0] len;
    } pkt_info_t;

    typedef enum logic [3:0] {
        OK                  = 4'd0,
        PARITY_FAIL         = 4'd1,
        WRONG_RSVD          = 4'd2,
        WRONG_TAIL          = 4'd3,
        WRONG_CRC           = 4'd4,
        UNSUPPORTED_MCS     = 4'd5,
        UNSUPPORTED_CBW     = 4'd6,
        HT_WRONG_RSVD       = 4'd7,
        UNSUPPORTED_STBC    = 4'd8,
        UNSUPPORTED_FEC     = 4'd9,
        UNSUPPORTED_SPATIAL = 4'd10,
        HT_WRONG_TAIL       = 4'd11,
        WRONG_FCS           = 4'd12
    } rx_status_t;

    typedef enum logic [3:0] {
        IDLE, SIGNAL, CHECK_SIGNAL, SIGNAL_ERROR, DETECT_HT,
        HT_SIGNAL, CHECK_HT_SIG, HT_SIG_ERROR, DATA, DONE
    } rx_state_t;

endpackage

// ==== include/rx_settings.svh ====
`ifndef RX_SETTINGS_SVH
`define RX_SETTINGS_SVH

//////////////////////////////
// sample and field sizes
//////////////////////////////

`define RX_IQ_WIDTH 16

`define RX_SIG_BYTES 3

// HT-SIG1 plus HT-SIG2
`define RX_HT_SIG_BYTES 6

// bits ahead of the crc field
`define RX_HT_CRC_BITS 34

//////////////////////////////
// HT detection and rates
//////////////////////////////

`define RX_HT_ROT_VOTES 4
`define RX_LEGACY_VOTES 5

// 6 Mb/s
`define RX_BPSK_RATE 4'b1011

`define RX_MAX_MCS 7

// crc-32 register after data plus a good fcs
`define RX_FCS_RESIDUE 32'hDEBB20E3

`endif

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f build.f --top-module rx_frame_tb -o rx_frame_sim

./obj_dir/rx_frame_sim | tee sim.log

if grep -qF '** FAIL **' sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation finished without failure"

// ==== include/rx_tb_frames.svh ====
`ifndef RX_TB_FRAMES_SVH
`define RX_TB_FRAMES_SVH

`include "rx_settings.svh"

//////////////////////////////
// frame table
//////////////////////////////

// ht: frame carries HT-SIG, rot: rotated samples after a BPSK SIGNAL
typedef struct packed {
    logic        ht;
    logic        rot;
    logic [3:0]  rate;
    logic        rsvd;
    logic [5:0]  tail;
    logic        bad_parity;
    logic [6:0]  mcs;
    logic        bad_crc;
    logic [7:0]  pay_len;
    logic        corrupt;
    rx_status_t  exp_status;
} frame_row_t;

localparam int FRAME_COUNT = 11;

// columns: ht rot rate rsvd tail bad_parity / mcs bad_crc pay_len corrupt status
function automatic frame_row_t frame_at(input int n);
    case (n)
        0: return '{1'b0, 1'b0, 4'b1111, 1'b0, 6'd0, 1'b0,
                    7'd0, 1'b0, 8'd20, 1'b0, OK};
        1: return '{1'b0, 1'b0, 4'b1111, 1'b0, 6'd0, 1'b1,
                    7'd0, 1'b0, 8'd20, 1'b0, PARITY_FAIL};
        2: return '{1'b0, 1'b0, 4'b0101, 1'b1, 6'd0, 1'b0,
                    7'd0, 1'b0, 8'd20, 1'b0, WRONG_RSVD};
        3: return '{1'b0, 1'b0, 4'b0111, 1'b0, 6'h15, 1'b0,
                    7'd0, 1'b0, 8'd20, 1'b0, WRONG_TAIL};
        4: return '{1'b0, 1'b0, 4'b0101, 1'b0, 6'd0, 1'b0,
                    7'd0, 1'b0, 8'd33, 1'b0, OK};
        5: return '{1'b0, 1'b0, 4'b1101, 1'b0, 6'd0, 1'b0,
                    7'd0, 1'b0, 8'd16, 1'b1, WRONG_FCS};
        6: return '{1'b0, 1'b0, `RX_BPSK_RATE, 1'b0, 6'd0, 1'b0,
                    7'd0, 1'b0, 8'd12, 1'b0, OK};
        7: return '{1'b1, 1'b1, `RX_BPSK_RATE, 1'b0, 6'd0, 1'b0,
                    7'd5, 1'b0, 8'd40, 1'b0, OK};
        8: return '{1'b1, 1'b1, `RX_BPSK_RATE, 1'b0, 6'd0, 1'b0,
                    7'd3, 1'b1, 8'd8, 1'b0, WRONG_CRC};
        9: return '{1'b1, 1'b1, `RX_BPSK_RATE, 1'b0, 6'd0, 1'b0,
                    7'd9, 1'b0, 8'd8, 1'b0, UNSUPPORTED_MCS};
        10: return '{1'b1, 1'b1, `RX_BPSK_RATE, 1'b0, 6'd0, 1'b0,
                     7'd0, 1'b0, 8'd6, 1'b0, OK};
        default: return '0;
    endcase
endfunction

//////////////////////////////
// reference models
//////////////////////////////

localparam logic [31:0] LCG_SEED = 32'd82;

logic [31:0] lcg_state;

function automatic logic [7:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
endfunction

// 802.11n HT-SIG crc, x^8 + x^2 + x + 1 over the first 34 bits
function automatic logic [7:0] ht_crc8(input logic [33:0] bits);
    logic [7:0] c;
    logic [7:0] res;
    logic       fb;
    c = 8'hff;
    for (int k = 0; k < 34; k++) begin
        fb = c[7] ^ bits[k];
        c  = {c[6:0], 1'b0} ^ (fb ? 8'h07 : 8'h00);
    end
    for (int k = 0; k < 8; k++) begin
        res[k] = ~c[7-k];
    end
    return res;
endfunction

// ethernet style crc-32, reflected
function automatic logic [31:0] crc32_update(input logic [31:0] crc, input logic [7:0] b);
    logic [31:0] c;
    c = crc ^ {24'd0, b};
    for (int k = 0; k < 8; k++) begin
        c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
    end
    return c;
endfunction

`endif

// ==== test/rx_frame_tb.sv ====
`timescale 1ns/10ps
`include "rx_settings.svh"

module rx_frame_tb
    import rx_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 200;
    localparam int SEL_SIG        = 0;
    localparam int SEL_HT         = 1;
    localparam int SEL_BEGIN      = 2;
    localparam int SEL_FCS        = 3;

    logic        clock;
    logic        ofdm_reset;
    logic        start_i;
    logic        byte_stb_i;
    logic [7:0]  byte_i;
    logic        sym_stb_i;
    iq_sample_t  sym_i;
    logic        sig_stb_o;
    legacy_sig_t sig_o;
    logic        ht_sig_stb_o;
    ht_sig_t     ht_sig_o;
    logic        ht_sig_crc_ok_o;
    logic        pkt_begin_o;
    pkt_info_t   pkt_o;
    logic        fcs_stb_o;
    logic        fcs_ok_o;
    rx_status_t  status_o;

    int          errors;
    int          checks;
    int          begin_seen;
    logic        timed_out;

    `include "rx_tb_frames.svh"

    rx_frame_top UUT (
        .clock, .ofdm_reset, .start_i, .byte_stb_i, .byte_i, .sym_stb_i, .sym_i,
        .sig_stb_o, .sig_o, .ht_sig_stb_o, .ht_sig_o, .ht_sig_crc_ok_o,
        .pkt_begin_o, .pkt_o, .fcs_stb_o, .fcs_ok_o, .status_o
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    // one cycle, ending at the falling edge; packet starts are counted here
    task automatic step();
        @(negedge clock);
        if (pkt_begin_o) begin
            begin_seen++;
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    function automatic logic strobe_level(input int sel);
        case (sel)
            SEL_SIG:   return sig_stb_o;
            SEL_HT:    return ht_sig_stb_o;
            SEL_BEGIN: return pkt_begin_o;
            default:   return fcs_stb_o;
        endcase
    endfunction

    task automatic await_strobe(input int sel, input string what);
        int n;
        n = 0;
        while (!strobe_level(sel) && n < TIMEOUT_CYCLES) begin
            step();
            n++;
        end
        if (!strobe_level(sel)) begin
            $display("timeout after %0d cycles waiting for %s", n, what);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        step();
        byte_stb_i = 1'b1;
        byte_i     = b;
    endtask

    task automatic send_sample(input logic rot);
        logic [7:0]  r_i;
        logic [7:0]  r_q;
        logic [15:0] mag_i;
        logic [15:0] mag_q;
        r_i = next_rand();
        r_q = next_rand();
        // rotated symbols carry their energy on Q
        mag_i = rot ? {8'd0, r_i} : 16'd2000 + {8'd0, r_i};
        mag_q = rot ? 16'd2000 + {8'd0, r_q} : {8'd0, r_q};
        step();
        sym_stb_i = 1'b1;
        sym_i.i   = r_q[0] ? -mag_i : mag_i;
        sym_i.q   = r_i[0] ? -mag_q : mag_q;
    endtask

    task automatic idle_inputs();
        step();
        byte_stb_i = 1'b0;
        sym_stb_i  = 1'b0;
    endtask

    task automatic expect_rejected(input rx_status_t exp, input int begins);
        check_value("status_o", 64'(status_o), 64'(exp));
        repeat (4) step();
        check_value("pkt_begin_o count", 64'(begin_seen - begins), 64'd0);
    endtask

    //////////////////////////////
    // one frame
    //////////////////////////////

    task automatic run_frame(input frame_row_t r);
        legacy_sig_t sig;
        ht_sig_t     hsig;
        pkt_info_t   exp_pkt;
        logic [7:0]  data [$];
        logic [31:0] crc;
        int          len;
        int          begins;
        int          votes;

        len    = int'(r.pay_len) + 4;
        begins = begin_seen;

        // even parity over rate, rsvd and len
        sig        = '0;
        sig.rate   = r.rate;
        sig.rsvd   = r.rsvd;
        sig.len    = 12'(len);
        sig.tail   = r.tail;
        sig.parity = (^sig[16:0]) ^ r.bad_parity;

        hsig              = '0;
        hsig.mcs          = r.mcs;
        hsig.len          = 16'(len);
        hsig.not_sounding = 1'b1;
        hsig.rsvd         = 1'b1;
        hsig.crc          = ht_crc8(hsig[33:0]) ^ (r.bad_crc ? 8'h5a : 8'h00);

        // payload then fcs, low byte first
        crc = '1;
        for (int i = 0; i < int'(r.pay_len); i++) begin
            data.push_back(next_rand());
            crc = crc32_update(crc, data[i]);
        end
        crc = ~crc;
        for (int k = 0; k < 4; k++) begin
            data.push_back(crc[8*k +: 8]);
        end
        if (r.corrupt) begin
            data[2] = data[2] ^ 8'h40;
        end

        exp_pkt.ht   = r.ht;
        exp_pkt.rate = r.ht ? {1'b1, r.mcs} : {4'b0, r.rate};
        exp_pkt.len  = 16'(len);

        step();
        start_i = 1'b1;
        step();
        start_i = 1'b0;
        for (int b = 0; b < `RX_SIG_BYTES; b++) begin
            send_byte(sig[8*b +: 8]);
        end
        idle_inputs();
        await_strobe(SEL_SIG, "sig_stb_o");
        if (timed_out) begin
            return;
        end
        check_value("sig_o", 64'(sig_o), 64'(sig));
        step();
        if (r.exp_status inside {PARITY_FAIL, WRONG_RSVD, WRONG_TAIL}) begin
            expect_rejected(r.exp_status, begins);
            return;
        end
        check_value("status_o", 64'(status_o), 64'(OK));

        if (r.rate == `RX_BPSK_RATE) begin
            votes = r.rot ? `RX_HT_ROT_VOTES : `RX_LEGACY_VOTES;
            for (int v = 0; v < votes; v++) begin
                send_sample(r.rot);
            end
            idle_inputs();
            if (r.ht) begin
                // ht decision pulse, then the controller arms HT-SIG
                step();
                for (int b = 0; b < `RX_HT_SIG_BYTES; b++) begin
                    send_byte(hsig[8*b +: 8]);
                end
                idle_inputs();
                await_strobe(SEL_HT, "ht_sig_stb_o");
                if (timed_out) begin
                    return;
                end
                check_value("ht_sig_crc_ok_o", 64'(ht_sig_crc_ok_o), 64'(!r.bad_crc));
                check_value("ht_sig_o", 64'(ht_sig_o), 64'(hsig));
                step();
                if (r.exp_status != OK && r.exp_status != WRONG_FCS) begin
                    expect_rejected(r.exp_status, begins);
                    return;
                end
            end
        end

        await_strobe(SEL_BEGIN, "pkt_begin_o");
        if (timed_out) begin
            return;
        end
        check_value("pkt_o", 64'(pkt_o), 64'(exp_pkt));
        foreach (data[i]) begin
            send_byte(data[i]);
        end
        idle_inputs();
        await_strobe(SEL_FCS, "fcs_stb_o");
        if (timed_out) begin
            return;
        end
        check_value("fcs_ok_o", 64'(fcs_ok_o), 64'(r.exp_status == OK));
        check_value("status_o", 64'(status_o), 64'(r.exp_status));
        check_value("pkt_begin_o count", 64'(begin_seen - begins), 64'd1);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        frame_row_t row;
        errors     = 0;
        checks     = 0;
        begin_seen = 0;
        timed_out  = 1'b0;
        lcg_state  = LCG_SEED;
        ofdm_reset = 1'b1;
        start_i    = 1'b0;
        byte_stb_i = 1'b0;
        byte_i     = '0;
        sym_stb_i  = 1'b0;
        sym_i      = '0;

        repeat (10) @(negedge clock);
        ofdm_reset = 1'b0;
        check_value("strobes after reset",
                    64'({sig_stb_o, ht_sig_stb_o, pkt_begin_o, fcs_stb_o,
                         fcs_ok_o, ht_sig_crc_ok_o}), 64'd0);
        check_value("status_o", 64'(status_o), 64'(OK));

        for (int n = 0; n < FRAME_COUNT && !timed_out; n++) begin
            row = frame_at(n);
            run_frame(row);
            repeat (4) step();
        end

        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
